/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = debug_terminal_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/debug_terminal_tb.sv */
/*
 * Testbench for the debug terminal top level.
 * Applies a table of command bytes and sensor values, checks flags and reset pulse,
 * and checks every 64-character line that arrives through a credit-returning link model.
 */
`timescale 1ns/100ps
`default_nettype none

module debug_terminal_tb;
  import term_cmd_pkg::*;
  import telemetry_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_ROWS     = 6;
  localparam int LOG_DEPTH    = 1024;
  // Worst case per row plus reset
  localparam int LIMIT = NUM_ROWS * (MSG_LEN * 8 + 60) + RESET_CYCLES;

  // One stimulus row with the flags expected after its command
  typedef struct packed {
    byte_t  cmd;
    stamp_t stamp;
    imu_t   acc;
    imu_t   gyr;
    logic   motor;
    logic   datalog;
  } row_t;

  logic   clk;
  logic   rst;
  byte_t  rx_data;
  logic   rx_valid;
  logic   tmr;
  stamp_t timestamp;
  imu_t   acc;
  imu_t   gyr;
  logic   credit_return = 1'b0;
  byte_t  tx_data;
  logic   tx_valid;
  logic   motor_armed;
  logic   datalog_on;
  logic   board_reset_req;

  row_t        table_rows [NUM_ROWS];
  row_t        row;
  byte_t       rx_log [LOG_DEPTH];
  int          rx_total = 0;
  int          cycle = 0;
  int          outstanding = 0;
  int          due_q [$];
  logic [31:0] rng = 32'h0687_57eb;
  int          r;
  int          i;
  int          base;
  logic        prev_motor;
  logic        prev_data;

  tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk (
    .clk (clk),
    .rst (rst)
  );

  debug_terminal dut (
    .clk             (clk),
    .rst             (rst),
    .rx_data         (rx_data),
    .rx_valid        (rx_valid),
    .tmr             (tmr),
    .timestamp       (timestamp),
    .acc             (acc),
    .gyr             (gyr),
    .credit_return   (credit_return),
    .tx_data         (tx_data),
    .tx_valid        (tx_valid),
    .motor_armed     (motor_armed),
    .datalog_on      (datalog_on),
    .board_reset_req (board_reset_req)
  );

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Decimal digit k of the stamp, by plain division
  function automatic logic [3:0] dec_digit(stamp_t value, int k);
    int unsigned v;
    v = 32'(value);
    for (int j = 0; j < k; j++) begin
      v = v / 10;
    end
    return 4'(v % 10);
  endfunction

  // Character idx of the line for one row
  function automatic byte_t expected_char(row_t rw, int idx);
    int         k;
    int         g;
    int         p;
    logic [7:0] hi;
    case (idx)
      0, 6, 62: return " ";
      1:  return 8'h30 + {4'h0, dec_digit(rw.stamp, 5)};
      2:  return 8'h30 + {4'h0, dec_digit(rw.stamp, 4)};
      3:  return 8'h30 + {4'h0, dec_digit(rw.stamp, 3)};
      4:  return ".";
      5:  return 8'h30 + {4'h0, dec_digit(rw.stamp, 2)};
      60: return rw.motor ? "A" : "D";
      61: return rw.datalog ? "R" : "I";
      63: return 8'h0D;
      default: begin
        // acc x,y,z then gyr x,y,z high bytes, MSB first, space after each
        k = idx - 7;
        g = k / 9;
        p = k % 9;
        if (g < 3) begin
          hi = rw.acc[47 - 16 * g -: 8];
        end else begin
          hi = rw.gyr[47 - 16 * (g - 3) -: 8];
        end
        if (p == 8) begin
          return " ";
        end
        return hi[7 - p] ? "1" : "0";
      end
    endcase
  endfunction

  // Run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > LIMIT) begin
      $display("Timeout: the run went past %0d cycles without finishing", LIMIT);
      $display("TESTBENCH FAILED");
      $fatal(1, "run limit reached");
    end
  end

  // Link model, logs bytes and frees each buffer slot after 0 to 7 cycles
  always @(posedge clk) begin
    if (rst) begin
      credit_return <= 1'b0;
    end else begin
      if (credit_return) begin
        outstanding = outstanding - 1;
      end
      if (tx_valid) begin
        check_value("rx log space", 32'd1, 32'(rx_total < LOG_DEPTH));
        rx_log[rx_total] <= tx_data;
        rx_total <= rx_total + 1;
        outstanding = outstanding + 1;
        rng = xorshift32(rng);
        due_q.push_back(cycle + int'(rng[2:0]));
      end
      // Bytes in the link buffer
      check_value("credit bound", 32'd0, 32'(outstanding > int'(TX_CREDITS)));
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        void'(due_q.pop_front());
        credit_return <= 1'b1;
      end else begin
        credit_return <= 1'b0;
      end
    end
  end

  initial begin
    rx_data   = '0;
    rx_valid  = 1'b0;
    tmr       = 1'b0;
    timestamp = '0;
    acc       = '0;
    gyr       = '0;

    table_rows[0] = '{cmd: "m", stamp: 24'd123456, acc: 48'hA5C3_0F81_7E00,
                      gyr: 48'h1234_FFEE_8001, motor: 1'b1, datalog: 1'b0};
    table_rows[1] = '{cmd: "d", stamp: 24'd16777215, acc: 48'h0000_FFFF_5555,
                      gyr: 48'hAAAA_0F0F_F0F0, motor: 1'b1, datalog: 1'b1};
    // Unknown byte leaves both flags
    table_rows[2] = '{cmd: "x", stamp: 24'd0, acc: 48'h8000_0100_7FFF,
                      gyr: 48'h3C3C_C3C3_0000, motor: 1'b1, datalog: 1'b1};
    table_rows[3] = '{cmd: "r", stamp: 24'd98765, acc: 48'hDEAD_BEEF_CAFE,
                      gyr: 48'h0102_0304_0506, motor: 1'b1, datalog: 1'b1};
    table_rows[4] = '{cmd: "m", stamp: 24'd4200, acc: 48'h1111_2222_3333,
                      gyr: 48'h4444_5555_6666, motor: 1'b0, datalog: 1'b1};
    table_rows[5] = '{cmd: "d", stamp: 24'd1000001, acc: 48'hFEDC_BA98_7654,
                      gyr: 48'h0F1E_2D3C_4B5A, motor: 1'b0, datalog: 1'b0};

    @(posedge clk);
    while (rst) @(posedge clk);

    // State right after reset
    check_value("reset motor_armed", 32'd0, 32'(motor_armed));
    check_value("reset datalog_on", 32'd0, 32'(datalog_on));
    check_value("reset tx_valid", 32'd0, 32'(tx_valid));
    check_value("reset board_reset_req", 32'd0, 32'(board_reset_req));
    prev_motor = 1'b0;
    prev_data  = 1'b0;

    for (r = 0; r < NUM_ROWS; r++) begin
      row = table_rows[r];
      rx_data   <= row.cmd;
      rx_valid  <= 1'b1;
      timestamp <= row.stamp;
      acc       <= row.acc;
      gyr       <= row.gyr;
      @(posedge clk);
      rx_valid <= 1'b0;
      // Command registered, flags not yet
      @(posedge clk);
      check_value($sformatf("row %0d motor early", r), 32'(prev_motor), 32'(motor_armed));
      check_value($sformatf("row %0d data early", r), 32'(prev_data), 32'(datalog_on));
      check_value($sformatf("row %0d reset early", r), 32'd0, 32'(board_reset_req));
      @(posedge clk);
      check_value($sformatf("row %0d motor", r), 32'(row.motor), 32'(motor_armed));
      check_value($sformatf("row %0d data", r), 32'(row.datalog), 32'(datalog_on));
      check_value($sformatf("row %0d reset pulse", r), 32'(row.cmd == CHAR_RESET),
                  32'(board_reset_req));
      tmr <= 1'b1;
      @(posedge clk);
      check_value($sformatf("row %0d reset end", r), 32'd0, 32'(board_reset_req));
      tmr  <= 1'b0;
      base = rx_total - 0;
      // Extra tick in the middle of the line
      while (rx_total - base < 10) @(posedge clk);
      tmr <= 1'b1;
      @(posedge clk);
      tmr <= 1'b0;
      while (rx_total - base < int'(MSG_LEN)) @(posedge clk);
      // Longer than a conversion, so a second line would show up
      repeat (40) @(posedge clk);
      check_value($sformatf("row %0d line length", r), 32'(MSG_LEN), 32'(rx_total - base));
      for (i = 0; i < int'(MSG_LEN); i++) begin
        check_value($sformatf("row %0d char %0d", r, i), 32'(expected_char(row, i)),
                    32'(rx_log[base + i]));
      end
      prev_motor = row.motor;
      prev_data  = row.datalog;
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
/*
 * Clock and reset source for the debug terminal testbench.
 * 10 ns clock; rst high for RESET_CYCLES rising edges, then released on an edge.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Synchronous release
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* src.f */
src/term_cmd_pkg.sv
src/telemetry_pkg.sv
src/cmd_decoder.sv
src/board_status.sv
src/bcd_timestamp.sv
src/debug_message_tx.sv
src/debug_terminal.sv
bench/tb_clock_gen.sv
bench/debug_terminal_tb.sv

/* src/bcd_timestamp.sv */
/*
 * Sequential binary to BCD converter for the 24-bit timestamp.
 * Shift and add 3, one input bit per cycle; pulse start, wait for done.
 * The result stays on bcd until the next start.
 */
`timescale 1ns/100ps
`default_nettype none

module bcd_timestamp (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  telemetry_pkg::stamp_t  bin,
  output telemetry_pkg::bcd_t    bcd,
  output logic                   done
);
  import telemetry_pkg::*;

  localparam int unsigned STEPS = $bits(stamp_t);

  logic [$clog2(STEPS+1)-1:0] count;
  logic                       busy;
  stamp_t                     shift;
  bcd_t                       adj;

  // One digit adder per nibble
  always_comb begin
    for (int i = 0; i < $bits(bcd_t) / 4; i++) begin
      if (bcd[4*i +: 4] >= 4'd5) begin
        adj[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
      end else begin
        adj[4*i +: 4] = bcd[4*i +: 4];
      end
    end
  end

  // Step counter and done pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= ($clog2(STEPS+1))'(STEPS);
      end else if (busy) begin
        count <= count - 1'b1;
        // Last bit shifted in on this edge
        if (count == 1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Datapath, MSB of the binary value first
  always_ff @(posedge clk) begin
    if (start) begin
      shift <= bin;
      bcd   <= '0;
    end else if (busy) begin
      shift <= shift << 1;
      bcd   <= {adj[$bits(bcd_t)-2:0], shift[STEPS-1]};
    end
  end

  // Transmitter must wait for the previous result
  a_no_restart : assert property (
    @(posedge clk) disable iff (rst)
    start |-> !busy
  ) else $error("bcd conversion restarted while busy");

endmodule

`default_nettype wire

/* src/board_status.sv */
/*
 * Board status register driven by decoded terminal commands.
 * Holds the motor arm and datalog flags and pulses the board reset request.
 */
`timescale 1ns/100ps
`default_nettype none

module board_status (
  input  logic                     clk,
  input  logic                     rst,
  input  term_cmd_pkg::term_cmd_t  cmd,
  output logic                     motor_armed,
  output logic                     datalog_on,
  output logic                     board_reset_req
);
  import term_cmd_pkg::*;

  logic is_reset;

  assign is_reset = cmd.valid && (cmd.cmd == CMD_RESET);

  always_ff @(posedge clk) begin
    if (rst) begin
      motor_armed     <= 1'b0;
      datalog_on      <= 1'b0;
      board_reset_req <= 1'b0;
    end else begin
      // One request cycle per reset command
      board_reset_req <= is_reset;
      if (cmd.valid) begin
        case (cmd.cmd)
          CMD_MOTOR: motor_armed <= ~motor_armed;
          CMD_DATA:  datalog_on  <= ~datalog_on;
          // Reset leaves both flags as they are
          default: begin
          end
        endcase
      end
    end
  end

  // Request is a single-cycle pulse
  a_reset_pulse : assert property (
    @(posedge clk) disable iff (rst)
    board_reset_req |=> !board_reset_req
  ) else $error("board_reset_req held for two cycles");

endmodule

`default_nettype wire

/* src/cmd_decoder.sv */
/*
 * Command decoder for bytes received from the host link.
 * Gives a registered command one cycle after a matching byte.
 */
`timescale 1ns/100ps
`default_nettype none

module cmd_decoder (
  input  logic                     clk,
  input  logic                     rst,
  input  term_cmd_pkg::byte_t      rx_data,
  input  logic                     rx_valid,
  output term_cmd_pkg::term_cmd_t  cmd
);
  import term_cmd_pkg::*;

  term_cmd_e match;

  // Character compare
  always_comb begin
    case (rx_data)
      CHAR_RESET: match = CMD_RESET;
      CHAR_MOTOR: match = CMD_MOTOR;
      CHAR_DATA:  match = CMD_DATA;
      default:    match = CMD_NONE;
    endcase
  end

  // Register the result
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd <= '{valid: 1'b0, cmd: CMD_NONE};
    end else begin
      // Unknown bytes are dropped here
      cmd.valid <= rx_valid && (match != CMD_NONE);
      if (rx_valid) begin
        cmd.cmd <= match;
      end else begin
        cmd.cmd <= CMD_NONE;
      end
    end
  end

endmodule

`default_nettype wire

/* src/debug_message_tx.sv */
/*
 * Debug line transmitter toward the host link.
 * Snapshots the sensors on a timer tick, converts the timestamp and sends
 * a 64-character ASCII line, one byte per available link credit.
 */
`timescale 1ns/100ps
`default_nettype none

module debug_message_tx (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tmr,
  input  telemetry_pkg::stamp_t  timestamp,
  input  telemetry_pkg::imu_t    acc,
  input  telemetry_pkg::imu_t    gyr,
  input  logic                   motor_armed,
  input  logic                   datalog_on,
  input  logic                   credit_return,
  output term_cmd_pkg::byte_t    tx_data,
  output logic                   tx_valid
);
  import telemetry_pkg::*;

  tx_state_e   state;
  msg_addr_t   addr;
  credit_t     credits;
  frame_t      frame;
  logic        conv_start;
  logic        conv_done;
  bcd_t        stamp_bcd;

  // Bit field decode of the character index
  logic [47:0] hi_bytes;
  msg_addr_t   field;
  logic [2:0]  group;
  logic [3:0]  pos;
  logic [5:0]  bit_sel;

  function automatic logic [7:0] ascii_digit(logic [3:0] d);
    return {4'h3, d};
  endfunction

  function automatic logic [7:0] ascii_bit(logic b);
    return b ? "1" : "0";
  endfunction

  // Converter runs off the captured stamp
  bcd_timestamp u_bcd (
    .clk   (clk),
    .rst   (rst),
    .start (conv_start),
    .bin   (frame.stamp),
    .bcd   (stamp_bcd),
    .done  (conv_done)
  );

  // A byte leaves only with a credit in hand
  assign tx_valid = (state == SEND) && (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      addr       <= '0;
      conv_start <= 1'b0;
      credits    <= credit_t'(TX_CREDITS);
    end else begin
      conv_start <= 1'b0;
      // Send and return may coincide
      credits    <= credits - credit_t'(tx_valid) + credit_t'(credit_return);
      case (state)
        IDLE: begin
          if (tmr) begin
            state      <= CONVERT;
            conv_start <= 1'b1;
          end
        end
        CONVERT: begin
          if (conv_done) begin
            state <= SEND;
          end
        end
        SEND: begin
          // Index wraps to zero after the last character
          if (tx_valid) begin
            addr <= addr + 1'b1;
            if (addr == msg_addr_t'(MSG_LEN - 1)) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Snapshot, ticks outside IDLE are ignored
  always_ff @(posedge clk) begin
    if (state == IDLE && tmr) begin
      frame <= '{stamp: timestamp, acc: acc, gyr: gyr,
                 motor_armed: motor_armed, datalog_on: datalog_on};
    end
  end

  // High bytes of acc x,y,z then gyr x,y,z
  assign hi_bytes = {frame.acc[47:40], frame.acc[31:24], frame.acc[15:8],
                     frame.gyr[47:40], frame.gyr[31:24], frame.gyr[15:8]};

  // Nine characters per byte, 8 bits and a space, from index 7
  assign field   = addr - msg_addr_t'(7);
  assign group   = 3'(field / 6'd9);
  assign pos     = 4'(field % 6'd9);
  assign bit_sel = 6'd47 - ({group, 3'b000} + 6'(pos));

  always_comb begin
    case (addr)
      6'd0, 6'd6, 6'd62: tx_data = " ";
      6'd1:  tx_data = ascii_digit(stamp_bcd[23:20]);
      6'd2:  tx_data = ascii_digit(stamp_bcd[19:16]);
      6'd3:  tx_data = ascii_digit(stamp_bcd[15:12]);
      6'd4:  tx_data = ".";
      6'd5:  tx_data = ascii_digit(stamp_bcd[11:8]);
      // Status letters replace the last separator
      6'd60: tx_data = frame.motor_armed ? "A" : "D";
      6'd61: tx_data = frame.datalog_on ? "R" : "I";
      6'd63: tx_data = 8'h0D;
      default: tx_data = (pos == 4'd8) ? " " : ascii_bit(hi_bytes[bit_sel]);
    endcase
  end

  // Link must not return more than it received
  a_credit_bound : assert property (
    @(posedge clk) disable iff (rst)
    credits <= credit_t'(TX_CREDITS)
  ) else $error("tx credit count above link buffer depth");

endmodule

`default_nettype wire

/* src/debug_terminal.sv */
/*
 * Debug terminal top level.
 * Decodes host commands, keeps the board flags and streams telemetry lines.
 */
`timescale 1ns/100ps
`default_nettype none

module debug_terminal (
  input  logic                   clk,
  input  logic                   rst,
  input  term_cmd_pkg::byte_t    rx_data,
  input  logic                   rx_valid,
  input  logic                   tmr,
  input  telemetry_pkg::stamp_t  timestamp,
  input  telemetry_pkg::imu_t    acc,
  input  telemetry_pkg::imu_t    gyr,
  input  logic                   credit_return,
  output term_cmd_pkg::byte_t    tx_data,
  output logic                   tx_valid,
  output logic                   motor_armed,
  output logic                   datalog_on,
  output logic                   board_reset_req
);
  import term_cmd_pkg::*;

  // Decode to execute
  term_cmd_t cmd;

  cmd_decoder u_decoder (
    .clk      (clk),
    .rst      (rst),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .cmd      (cmd)
  );

  board_status u_status (
    .clk             (clk),
    .rst             (rst),
    .cmd             (cmd),
    .motor_armed     (motor_armed),
    .datalog_on      (datalog_on),
    .board_reset_req (board_reset_req)
  );

  // Flags also go into the line
  debug_message_tx u_tx (
    .clk           (clk),
    .rst           (rst),
    .tmr           (tmr),
    .timestamp     (timestamp),
    .acc           (acc),
    .gyr           (gyr),
    .motor_armed   (motor_armed),
    .datalog_on    (datalog_on),
    .credit_return (credit_return),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid)
  );

endmodule

`default_nettype wire

/* src/telemetry_pkg.sv */
/*
 * Telemetry types for the debug message transmitter.
 * Sensor and timestamp widths, line length, link credits and the frame snapshot.
 */
`default_nettype none

package telemetry_pkg;

  // Binary timestamp and its 8-digit BCD form
  typedef logic [23:0] stamp_t;
  typedef logic [31:0] bcd_t;

  // Three 16-bit axes, x on top
  typedef logic [47:0] imu_t;

  // Fixed line of 64 characters
  localparam int unsigned MSG_LEN = 64;
  typedef logic [$clog2(MSG_LEN)-1:0] msg_addr_t;

  // Link buffer depth, counter must hold the full value
  localparam int unsigned TX_CREDITS = 4;
  typedef logic [$clog2(TX_CREDITS+1)-1:0] credit_t;

  // Values frozen at the timer tick
  typedef struct packed {
    stamp_t stamp;
    imu_t   acc;
    imu_t   gyr;
    logic   motor_armed;
    logic   datalog_on;
  } frame_t;

  typedef enum logic [1:0] {IDLE, CONVERT, SEND} tx_state_e;

endpackage

`default_nettype wire

/* src/term_cmd_pkg.sv */
/*
 * Command encodings for the debug terminal host link.
 * Imported by the command decoder, the board status register and the top level.
 */
`default_nettype none

package term_cmd_pkg;

  // One character on the host link
  typedef logic [7:0] byte_t;

  // Single-letter commands typed at the terminal
  localparam byte_t CHAR_RESET = "r";
  localparam byte_t CHAR_MOTOR = "m";
  localparam byte_t CHAR_DATA  = "d";

  // Decoded command, CMD_NONE for anything unknown
  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_RESET,
    CMD_MOTOR,
    CMD_DATA
  } term_cmd_e;

  // Registered command from decoder to status register
  typedef struct packed {
    logic      valid;
    term_cmd_e cmd;
  } term_cmd_t;

endpackage

`default_nettype wire
